/* design/rv_core_pkg.sv */
package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // Source of an execute operand
    typedef enum logic [1:0] {
        FWD_ID_EX  = 2'd0,
        FWD_EX_MEM = 2'd1,
        FWD_MEM_WB = 2'd2
    } fwd_sel_e;

    // ==============================
    // Instruction formats
    // ==============================

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0]           imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } instr_u;

    // ==============================
    // Pipeline registers
    // ==============================

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        logic    op1_pc;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
    } id_ex_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_read;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
    } mem_wb_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            we;
        logic            re;
    } dmem_req_t;

endpackage

/* design/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         stall_i,
    input  logic [rv_core_pkg::XLEN-1:0] imem_data_i,
    output logic [rv_core_pkg::XLEN-1:0] imem_addr_o,
    output rv_core_pkg::if_id_t          if_id_o
);

    logic [rv_core_pkg::XLEN-1:0] pc_q;

    // PC and IF/ID advance together, both frozen on a load-use stall
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q          <= RESET_PC;
            if_id_o.pc    <= RESET_PC;
            if_id_o.instr <= rv_core_pkg::NOP_INSTR;
        end else if (!stall_i) begin
            pc_q          <= pc_q + rv_core_pkg::XLEN'(4);
            if_id_o.pc    <= pc_q;
            if_id_o.instr <= imem_data_i;
        end
    end

    // Instruction memory answers in the same cycle
    assign imem_addr_o = pc_q;

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                               clk,
    input  logic                               reset_i,
    input  logic                               we_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [rv_core_pkg::XLEN-1:0]       wdata_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [rv_core_pkg::XLEN-1:0]       rdata1_o,
    output logic [rv_core_pkg::XLEN-1:0]       rdata2_o
);

    logic [rv_core_pkg::XLEN-1:0] regs_q [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regs_q <= '{default: '0};
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Write-before-read bypass, x0 hardwired
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (we_i && waddr_i == raddr1_i) ? wdata_i : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (we_i && waddr_i == raddr2_i) ? wdata_i : regs_q[raddr2_i];

endmodule

/* design/alu.sv */
`timescale 1ns/1ps

module alu (
    input  rv_core_pkg::alu_op_e          op_i,
    input  logic [rv_core_pkg::XLEN-1:0]  a_i,
    input  logic [rv_core_pkg::XLEN-1:0]  b_i,
    output logic [rv_core_pkg::XLEN-1:0]  result_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            rv_core_pkg::ALU_ADD:    result_o = a_i + b_i;
            rv_core_pkg::ALU_SUB:    result_o = a_i - b_i;
            rv_core_pkg::ALU_SLL:    result_o = a_i << shamt;
            rv_core_pkg::ALU_SLT:    result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            rv_core_pkg::ALU_SLTU:   result_o = {31'b0, a_i < b_i};
            rv_core_pkg::ALU_XOR:    result_o = a_i ^ b_i;
            rv_core_pkg::ALU_SRL:    result_o = a_i >> shamt;
            rv_core_pkg::ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
            rv_core_pkg::ALU_OR:     result_o = a_i | b_i;
            rv_core_pkg::ALU_AND:    result_o = a_i & b_i;
            // LUI passes the upper immediate straight through
            rv_core_pkg::ALU_PASS_B: result_o = b_i;
            default:                 result_o = '0;
        endcase
    end

endmodule

/* design/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_i,
    input  rv_core_pkg::id_ex_t                id_ex_i,
    input  rv_core_pkg::ex_mem_t               ex_mem_i,
    input  rv_core_pkg::mem_wb_t               mem_wb_i,
    output logic                               stall_o,
    output rv_core_pkg::fwd_sel_e              fwd_a_o,
    output rv_core_pkg::fwd_sel_e              fwd_b_o
);

    // Youngest producer wins, loads only forward from writeback
    function automatic rv_core_pkg::fwd_sel_e fwd_pick(
        input logic [rv_core_pkg::REG_ADDR_W-1:0] rs,
        input rv_core_pkg::ex_mem_t               ex_mem,
        input rv_core_pkg::mem_wb_t               mem_wb
    );
        if (rs == '0) begin
            return rv_core_pkg::FWD_ID_EX;
        end
        if (ex_mem.reg_write && !ex_mem.mem_read && ex_mem.rd == rs) begin
            return rv_core_pkg::FWD_EX_MEM;
        end
        if (mem_wb.reg_write && mem_wb.rd == rs) begin
            return rv_core_pkg::FWD_MEM_WB;
        end
        return rv_core_pkg::FWD_ID_EX;
    endfunction

    assign fwd_a_o = fwd_pick(id_ex_i.rs1, ex_mem_i, mem_wb_i);
    assign fwd_b_o = fwd_pick(id_ex_i.rs2, ex_mem_i, mem_wb_i);

    // Load-use, one bubble lets the load reach writeback
    assign stall_o = id_ex_i.ctrl.mem_read && id_ex_i.rd != '0
                     && (id_ex_i.rd == rs1_i || id_ex_i.rd == rs2_i);

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                               clk,
    input  logic                               reset_i,
    input  logic                               stall_i,
    input  rv_core_pkg::if_id_t                if_id_i,
    input  rv_core_pkg::mem_wb_t               mem_wb_i,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_o,
    output rv_core_pkg::id_ex_t                id_ex_o
);

    rv_core_pkg::instr_u          instr;
    rv_core_pkg::ctrl_t           ctrl;
    logic [rv_core_pkg::XLEN-1:0] imm;
    logic [rv_core_pkg::XLEN-1:0] rs1_data;
    logic [rv_core_pkg::XLEN-1:0] rs2_data;
    logic                         shift_f3;
    logic                         f7_base;
    logic                         f7_alt;

    function automatic rv_core_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            3'b001:  return rv_core_pkg::ALU_SLL;
            3'b010:  return rv_core_pkg::ALU_SLT;
            3'b011:  return rv_core_pkg::ALU_SLTU;
            3'b100:  return rv_core_pkg::ALU_XOR;
            3'b101:  return alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'b110:  return rv_core_pkg::ALU_OR;
            default: return rv_core_pkg::ALU_AND;
        endcase
    endfunction

    assign instr    = if_id_i.instr;
    assign shift_f3 = instr.r.funct3 == 3'b001 || instr.r.funct3 == 3'b101;
    assign f7_base  = instr.r.funct7 == 7'h00;
    // funct7 of 0x20 only selects SUB and SRA
    assign f7_alt   = instr.r.funct7 == 7'h20
                      && (instr.r.funct3 == 3'b000 || instr.r.funct3 == 3'b101);

    // Control decode, anything unrecognized stays a no-op
    always_comb begin
        ctrl  = '0;
        imm   = '0;
        rs1_o = '0;
        rs2_o = '0;
        case (instr.r.opcode)
            rv_core_pkg::OPC_OP: begin
                if (f7_base || f7_alt) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_op    = alu_sel(instr.r.funct3, instr.r.funct7[5]);
                    rs1_o          = instr.r.rs1;
                    rs2_o          = instr.r.rs2;
                end
            end
            rv_core_pkg::OPC_OP_IMM: begin
                // Shift amounts reuse the upper immediate bits as funct7
                if (!shift_f3 || f7_base || (f7_alt && instr.r.funct3 == 3'b101)) begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.alu_op      = alu_sel(instr.r.funct3, shift_f3 && instr.r.funct7[5]);
                    imm              = {{20{instr.i.imm[11]}}, instr.i.imm};
                    rs1_o            = instr.i.rs1;
                end
            end
            rv_core_pkg::OPC_LUI, rv_core_pkg::OPC_AUIPC: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.op1_pc      = instr.u.opcode == rv_core_pkg::OPC_AUIPC;
                ctrl.alu_op      = ctrl.op1_pc ? rv_core_pkg::ALU_ADD : rv_core_pkg::ALU_PASS_B;
                imm              = {instr.u.imm, 12'b0};
            end
            rv_core_pkg::OPC_LOAD: begin
                if (instr.i.funct3 == 3'b010) begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.mem_read    = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    imm              = {{20{instr.i.imm[11]}}, instr.i.imm};
                    rs1_o            = instr.i.rs1;
                end
            end
            rv_core_pkg::OPC_STORE: begin
                if (instr.s.funct3 == 3'b010) begin
                    ctrl.mem_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    imm              = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
                    rs1_o            = instr.s.rs1;
                    rs2_o            = instr.s.rs2;
                end
            end
            default: ;
        endcase
    end

    reg_file u_reg_file (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (mem_wb_i.reg_write),
        .waddr_i  (mem_wb_i.rd),
        .wdata_i  (mem_wb_i.result),
        .raddr1_i (rs1_o),
        .raddr2_i (rs2_o),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    // ID/EX register, a stall inserts a bubble
    always_ff @(posedge clk) begin
        if (reset_i || stall_i) begin
            id_ex_o.ctrl <= '0;
        end else begin
            id_ex_o.ctrl <= ctrl;
        end
        id_ex_o.pc       <= if_id_i.pc;
        id_ex_o.rs1      <= rs1_o;
        id_ex_o.rs2      <= rs2_o;
        id_ex_o.rd       <= instr.r.rd;
        id_ex_o.rs1_data <= rs1_data;
        id_ex_o.rs2_data <= rs2_data;
        id_ex_o.imm      <= imm;
    end

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                         clk,
    input  logic                         reset_i,
    input  rv_core_pkg::id_ex_t          id_ex_i,
    input  rv_core_pkg::fwd_sel_e        fwd_a_i,
    input  rv_core_pkg::fwd_sel_e        fwd_b_i,
    input  logic [rv_core_pkg::XLEN-1:0] wb_data_i,
    output rv_core_pkg::ex_mem_t         ex_mem_o
);

    logic [rv_core_pkg::XLEN-1:0] src_a;
    logic [rv_core_pkg::XLEN-1:0] src_b;
    logic [rv_core_pkg::XLEN-1:0] op_a;
    logic [rv_core_pkg::XLEN-1:0] op_b;
    logic [rv_core_pkg::XLEN-1:0] alu_result;

    function automatic logic [rv_core_pkg::XLEN-1:0] fwd_mux(
        input rv_core_pkg::fwd_sel_e        sel,
        input logic [rv_core_pkg::XLEN-1:0] stage_val,
        input logic [rv_core_pkg::XLEN-1:0] ex_mem_val,
        input logic [rv_core_pkg::XLEN-1:0] wb_val
    );
        case (sel)
            rv_core_pkg::FWD_EX_MEM: return ex_mem_val;
            rv_core_pkg::FWD_MEM_WB: return wb_val;
            default:                 return stage_val;
        endcase
    endfunction

    // ==============================
    // Operand forwarding and select
    // ==============================
    assign src_a = fwd_mux(fwd_a_i, id_ex_i.rs1_data, ex_mem_o.alu_result, wb_data_i);
    assign src_b = fwd_mux(fwd_b_i, id_ex_i.rs2_data, ex_mem_o.alu_result, wb_data_i);

    assign op_a = id_ex_i.ctrl.op1_pc ? id_ex_i.pc : src_a;
    assign op_b = id_ex_i.ctrl.alu_src_imm ? id_ex_i.imm : src_b;

    alu u_alu (
        .op_i     (id_ex_i.ctrl.alu_op),
        .a_i      (op_a),
        .b_i      (op_b),
        .result_o (alu_result)
    );

    // EX/MEM register, store data is the forwarded rs2
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_mem_o.reg_write <= 1'b0;
            ex_mem_o.mem_read  <= 1'b0;
            ex_mem_o.mem_write <= 1'b0;
        end else begin
            ex_mem_o.reg_write <= id_ex_i.ctrl.reg_write;
            ex_mem_o.mem_read  <= id_ex_i.ctrl.mem_read;
            ex_mem_o.mem_write <= id_ex_i.ctrl.mem_write;
        end
        ex_mem_o.rd         <= id_ex_i.rd;
        ex_mem_o.alu_result <= alu_result;
        ex_mem_o.store_data <= src_b;
    end

endmodule

/* design/mem_wb_stage.sv */
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic                         clk,
    input  logic                         reset_i,
    input  rv_core_pkg::ex_mem_t         ex_mem_i,
    input  logic [rv_core_pkg::XLEN-1:0] dmem_rdata_i,
    output rv_core_pkg::dmem_req_t       dmem_req_o,
    output rv_core_pkg::mem_wb_t         mem_wb_o,
    output logic [rv_core_pkg::XLEN-1:0] wb_data_o
);

    rv_core_pkg::mem_wb_t mem_wb_q;

    // Data memory request straight from EX/MEM
    assign dmem_req_o.addr  = ex_mem_i.alu_result;
    assign dmem_req_o.wdata = ex_mem_i.store_data;
    assign dmem_req_o.we    = ex_mem_i.mem_write;
    assign dmem_req_o.re    = ex_mem_i.mem_read;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_wb_q.reg_write <= 1'b0;
            mem_wb_q.mem_read  <= 1'b0;
        end else begin
            mem_wb_q.reg_write <= ex_mem_i.reg_write;
            mem_wb_q.mem_read  <= ex_mem_i.mem_read;
        end
        mem_wb_q.rd     <= ex_mem_i.rd;
        mem_wb_q.result <= ex_mem_i.alu_result;
    end

    // Load data arrives one cycle after the read, during writeback
    assign wb_data_o = mem_wb_q.mem_read ? dmem_rdata_i : mem_wb_q.result;

    always_comb begin
        mem_wb_o        = mem_wb_q;
        mem_wb_o.result = wb_data_o;
    end

endmodule

/* design/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                         clk,
    input  logic                         reset_i,
    output logic [rv_core_pkg::XLEN-1:0] imem_addr_o,
    input  logic [rv_core_pkg::XLEN-1:0] imem_data_i,
    output rv_core_pkg::dmem_req_t       dmem_req_o,
    input  logic [rv_core_pkg::XLEN-1:0] dmem_rdata_i
);

    rv_core_pkg::if_id_t                if_id;
    rv_core_pkg::id_ex_t                id_ex;
    rv_core_pkg::ex_mem_t               ex_mem;
    rv_core_pkg::mem_wb_t               mem_wb;
    rv_core_pkg::fwd_sel_e              fwd_a;
    rv_core_pkg::fwd_sel_e              fwd_b;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_id;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_id;
    logic [rv_core_pkg::XLEN-1:0]       wb_data;
    logic                               stall;

    // ==============================
    // Pipeline stages
    // ==============================

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk         (clk),
        .reset_i     (reset_i),
        .stall_i     (stall),
        .imem_data_i (imem_data_i),
        .imem_addr_o (imem_addr_o),
        .if_id_o     (if_id)
    );

    decode_stage u_decode (
        .clk      (clk),
        .reset_i  (reset_i),
        .stall_i  (stall),
        .if_id_i  (if_id),
        .mem_wb_i (mem_wb),
        .rs1_o    (rs1_id),
        .rs2_o    (rs2_id),
        .id_ex_o  (id_ex)
    );

    execute_stage u_execute (
        .clk       (clk),
        .reset_i   (reset_i),
        .id_ex_i   (id_ex),
        .fwd_a_i   (fwd_a),
        .fwd_b_i   (fwd_b),
        .wb_data_i (wb_data),
        .ex_mem_o  (ex_mem)
    );

    mem_wb_stage u_mem_wb (
        .clk          (clk),
        .reset_i      (reset_i),
        .ex_mem_i     (ex_mem),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_req_o   (dmem_req_o),
        .mem_wb_o     (mem_wb),
        .wb_data_o    (wb_data)
    );

    hazard_unit u_hazard (
        .rs1_i    (rs1_id),
        .rs2_i    (rs2_id),
        .id_ex_i  (id_ex),
        .ex_mem_i (ex_mem),
        .mem_wb_i (mem_wb),
        .stall_o  (stall),
        .fwd_a_o  (fwd_a),
        .fwd_b_o  (fwd_b)
    );

endmodule

/* dv/rv_core_model.svh */
`ifndef RV_CORE_MODEL_SVH
`define RV_CORE_MODEL_SVH

// Architectural state of the instruction-level model
logic [31:0] model_regs [32];
logic [31:0] model_mem [256];
logic [31:0] exp_st_addr [$];
logic [31:0] exp_st_data [$];
int          model_loads;

function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

// RV32I integer arithmetic by funct3, alt selects SUB or SRA
function automatic logic [31:0] rv_arith(
    input logic [2:0]  f3,
    input logic        alt,
    input logic [31:0] a,
    input logic [31:0] b
);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

// One instruction at a time, in program order
task automatic model_run();
    rv_core_pkg::instr_u iw;
    logic [31:0]         a;
    logic [31:0]         b;
    logic [31:0]         res;
    logic [31:0]         addr;
    logic                wr;
    int                  i;
    for (i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
    for (i = 0; i < 256; i++) begin
        model_mem[i] = fill_word(i);
    end
    model_loads = 0;
    for (i = 0; i < PROG_LEN; i++) begin
        iw  = prog[i];
        a   = model_regs[iw.r.rs1];
        b   = model_regs[iw.r.rs2];
        wr  = 1'b1;
        res = '0;
        case (iw.r.opcode)
            rv_core_pkg::OPC_OP: begin
                res = rv_arith(iw.r.funct3, iw.r.funct7[5], a, b);
            end
            rv_core_pkg::OPC_OP_IMM: begin
                // Only SRAI uses the alternate form
                res = rv_arith(iw.i.funct3, iw.i.funct3 == 3'd5 && iw.i.imm[10],
                               a, sext12(iw.i.imm));
            end
            rv_core_pkg::OPC_LUI: begin
                res = {iw.u.imm, 12'b0};
            end
            rv_core_pkg::OPC_AUIPC: begin
                res = RESET_PC + 32'(4 * i) + {iw.u.imm, 12'b0};
            end
            rv_core_pkg::OPC_LOAD: begin
                addr = a + sext12(iw.i.imm);
                res  = model_mem[addr[9:2]];
                wr   = iw.i.funct3 == 3'b010;
                model_loads += int'(wr);
            end
            rv_core_pkg::OPC_STORE: begin
                wr   = 1'b0;
                addr = a + sext12({iw.s.imm_hi, iw.s.imm_lo});
                if (iw.s.funct3 == 3'b010) begin
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                    model_mem[addr[9:2]] = b;
                end
            end
            default: wr = 1'b0;
        endcase
        if (wr && iw.r.rd != 5'd0) begin
            model_regs[iw.r.rd] = res;
        end
    end
endtask

`endif

/* dv/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    localparam logic [31:0] RESET_PC  = '0;
    localparam int          N_RAND    = 300;
    localparam int          PROG_LEN  = N_RAND + 31;
    localparam int          DUMP_BASE = 224;
    localparam int          WATCHDOG  = PROG_LEN * 2 + 100;

    logic                   clk;
    logic                   reset_i;
    logic [31:0]            imem_addr_o;
    logic [31:0]            imem_data_i;
    rv_core_pkg::dmem_req_t dmem_req_o;
    logic [31:0]            dmem_rdata_i;

    logic [31:0] prog [PROG_LEN];
    logic [31:0] dmem [256];
    int          test_checks [5];
    int          test_errs [5];
    string       test_names [5] = '{"reset", "store_stream", "load_use",
                                    "fetch_order", "final_state"};
    int          st_idx;
    int          dut_loads;
    int          dut_repeats;
    int          run_cycles;
    logic [31:0] exp_pc;
    logic [31:0] prev_addr;
    logic        held;

    rv_core_top #(
        .RESET_PC (RESET_PC)
    ) DUT (
        .clk          (clk),
        .reset_i      (reset_i),
        .imem_addr_o  (imem_addr_o),
        .imem_data_i  (imem_data_i),
        .dmem_req_o   (dmem_req_o),
        .dmem_rdata_i (dmem_rdata_i)
    );

    always #50 clk = ~clk;

    // Per-word fill pattern over the full word address
    function automatic logic [31:0] fill_word(input int w);
        return (32'(w) * 32'h9E37_79B9) ^ 32'h5A5A_0000;
    endfunction

    function automatic logic [31:0] instr_at(input int idx);
        return (idx >= 0 && idx < PROG_LEN) ? prog[idx] : rv_core_pkg::NOP_INSTR;
    endfunction

    // Does nx read the nonzero rd of the load ld
    function automatic logic load_use(input logic [31:0] ld, input logic [31:0] nx);
        rv_core_pkg::instr_u l;
        rv_core_pkg::instr_u n;
        logic                uses1;
        logic                uses2;
        l = ld;
        n = nx;
        if (l.i.opcode != rv_core_pkg::OPC_LOAD || l.i.rd == 5'd0) begin
            return 1'b0;
        end
        uses1 = n.r.opcode inside {rv_core_pkg::OPC_OP, rv_core_pkg::OPC_OP_IMM,
                                   rv_core_pkg::OPC_LOAD, rv_core_pkg::OPC_STORE};
        uses2 = n.r.opcode inside {rv_core_pkg::OPC_OP, rv_core_pkg::OPC_STORE};
        return (uses1 && n.r.rs1 == l.i.rd) || (uses2 && n.r.rs2 == l.i.rd);
    endfunction

    // Fetch of idx is repeated when the two before it form a load-use pair
    function automatic logic stall_before(input int idx);
        return idx >= 2 && load_use(instr_at(idx - 2), instr_at(idx - 1));
    endfunction

    `include "rv_core_model.svh"

    task automatic compare_value(
        input int          t,
        input string       name,
        input logic [31:0] exp_val,
        input logic [31:0] act_val
    );
        test_checks[t]++;
        if (act_val !== exp_val) begin
            test_errs[t]++;
            $display("MISMATCH time=%0t signal=%s expected=%08h actual=%08h",
                     $time, name, exp_val, act_val);
        end
    endtask

    function automatic logic [4:0] pick_reg();
        return 5'($urandom % 8);
    endfunction

    // ==============================
    // Program generation
    // ==============================
    task automatic gen_program();
        rv_core_pkg::instr_u iw;
        int unsigned         kind;
        logic [2:0]          f3;
        int                  i;
        for (i = 0; i < N_RAND; i++) begin
            iw          = '0;
            kind        = $urandom % 20;
            f3          = 3'($urandom % 8);
            iw.r.rd     = pick_reg();
            iw.r.rs1    = pick_reg();
            iw.r.rs2    = pick_reg();
            iw.r.funct3 = f3;
            if (kind < 6) begin
                iw.r.opcode = rv_core_pkg::OPC_OP;
                iw.r.funct7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2) ? 7'h20 : 7'h00;
            end else if (kind < 11) begin
                iw.i.opcode = rv_core_pkg::OPC_OP_IMM;
                iw.i.imm    = 12'($urandom);
                if (f3 == 3'd1) begin
                    iw.i.imm[11:5] = 7'h00;
                end else if (f3 == 3'd5) begin
                    iw.i.imm[11:5] = ($urandom % 2) ? 7'h20 : 7'h00;
                end
            end else if (kind < 13) begin
                iw.u.opcode = (kind == 11) ? rv_core_pkg::OPC_LUI : rv_core_pkg::OPC_AUIPC;
                iw.u.imm    = 20'($urandom);
            end else if (kind < 17) begin
                iw.i.opcode = rv_core_pkg::OPC_LOAD;
                iw.i.funct3 = 3'b010;
                iw.i.rs1    = 5'd0;
                iw.i.imm    = {2'b00, 8'($urandom), 2'b00};
            end else begin
                iw.s.opcode = rv_core_pkg::OPC_STORE;
                iw.s.funct3 = 3'b010;
                iw.s.rs1    = 5'd0;
                {iw.s.imm_hi, iw.s.imm_lo} = {2'b00, 8'($urandom), 2'b00};
            end
            prog[i] = iw;
        end
        // Register dump x1..x31 to the top of data memory
        for (i = 1; i < 32; i++) begin
            iw          = '0;
            iw.s.opcode = rv_core_pkg::OPC_STORE;
            iw.s.funct3 = 3'b010;
            iw.s.rs2    = 5'(i);
            {iw.s.imm_hi, iw.s.imm_lo} = 12'((DUMP_BASE + i) * 4);
            prog[N_RAND + i - 1] = iw;
        end
    endtask

    assign imem_data_i = (imem_addr_o < 32'(4 * PROG_LEN)) ? prog[imem_addr_o[31:2]]
                                                            : rv_core_pkg::NOP_INSTR;

    // Data memory, write commits at the edge and reads return a cycle later
    always @(posedge clk) begin
        if (dmem_req_o.we === 1'b1) begin
            dmem[dmem_req_o.addr[9:2]] <= dmem_req_o.wdata;
        end
        if (dmem_req_o.re === 1'b1) begin
            dmem_rdata_i <= dmem[dmem_req_o.addr[9:2]];
        end
    end

    // ==============================
    // Output monitor
    // ==============================
    always @(negedge clk) begin
        if (reset_i || run_cycles == 0) begin
            compare_value(0, "dmem_req_o.we", 32'd0, 32'(dmem_req_o.we));
            compare_value(0, "dmem_req_o.re", 32'd0, 32'(dmem_req_o.re));
            compare_value(0, "imem_addr_o", RESET_PC, imem_addr_o);
        end
        if (!reset_i) begin
            if (run_cycles > 0 && imem_addr_o === prev_addr) begin
                dut_repeats++;
            end
            prev_addr = imem_addr_o;
            run_cycles++;
            compare_value(3, "imem_addr_o", exp_pc, imem_addr_o);
            if (!held && stall_before(int'((exp_pc - RESET_PC) >> 2))) begin
                held = 1'b1;
            end else begin
                held   = 1'b0;
                exp_pc = exp_pc + 32'd4;
            end
            if (dmem_req_o.re === 1'b1) begin
                dut_loads++;
            end
            if (dmem_req_o.we === 1'b1) begin
                if (st_idx < exp_st_addr.size()) begin
                    compare_value(1, "dmem_req_o.addr", exp_st_addr[st_idx], dmem_req_o.addr);
                    compare_value(1, "dmem_req_o.wdata", exp_st_data[st_idx], dmem_req_o.wdata);
                end else begin
                    test_errs[1]++;
                    $display("ERROR: time=%0t the core stored to %08h after all expected stores",
                             $time, dmem_req_o.addr);
                end
                st_idx++;
            end
        end
    end

    initial begin
        int i;
        int pairs;
        int total_checks;
        int total_errs;
        clk          = 1'b0;
        reset_i      = 1'b1;
        dmem_rdata_i = '0;
        st_idx       = 0;
        dut_loads    = 0;
        dut_repeats  = 0;
        run_cycles   = 0;
        exp_pc       = RESET_PC;
        prev_addr    = '0;
        held         = 1'b0;
        void'($urandom(11843));
        gen_program();
        model_run();
        for (i = 0; i < 256; i++) begin
            dmem[i] = fill_word(i);
        end
        pairs = 0;
        for (i = 0; i + 1 < PROG_LEN; i++) begin
            pairs += int'(load_use(prog[i], prog[i + 1]));
        end

        repeat (16) @(posedge clk);
        reset_i <= 1'b0;

        while (st_idx < exp_st_addr.size()) begin
            @(negedge clk);
        end
        // Let the last write land and catch any stray store
        repeat (8) @(negedge clk);

        compare_value(2, "load count", 32'(model_loads), 32'(dut_loads));
        compare_value(2, "load-use stalls", 32'(pairs), 32'(dut_repeats));
        compare_value(4, "store count", 32'(exp_st_addr.size()), 32'(st_idx));
        for (i = 1; i < 32; i++) begin
            compare_value(4, $sformatf("x%0d", i), model_regs[i], dmem[DUMP_BASE + i]);
        end
        for (i = 0; i < 256; i++) begin
            compare_value(4, $sformatf("dmem[%0d]", i), model_mem[i], dmem[i]);
        end

        total_checks = 0;
        total_errs   = 0;
        for (i = 0; i < 5; i++) begin
            $display("test %-12s checks=%0d errors=%0d", test_names[i],
                     test_checks[i], test_errs[i]);
            total_checks += test_checks[i];
            total_errs   += test_errs[i];
        end
        $display("tests=5 checks=%0d errors=%0d", total_checks, total_errs);
        if (total_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog sized from the program length
    initial begin
        @(negedge reset_i);
        repeat (WATCHDOG) @(posedge clk);
        $display("ERROR: run timed out after %0d cycles with %0d of %0d stores seen",
                 WATCHDOG, st_idx, exp_st_addr.size());
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+dv
design/rv_core_pkg.sv
design/fetch_unit.sv
design/reg_file.sv
design/alu.sv
design/hazard_unit.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/rv_core_top.sv
dv/tb_rv_core.sv
